//--- rtl/dsp_tx_pkg.sv
package dsp_tx_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   localparam logic [ADDR_W-1:0] SR_BASE      = 8'd128;
   localparam logic [ADDR_W-1:0] SR_PHASE_INC = SR_BASE + 8'd0;
   localparam logic [ADDR_W-1:0] SR_SCALE     = SR_BASE + 8'd1;  // {scale_i, scale_q}
   localparam logic [ADDR_W-1:0] SR_RATE      = SR_BASE + 8'd2;
   localparam logic [ADDR_W-1:0] SR_DACMUX    = SR_BASE + 8'd4;  // {mux_b, mux_a}

   localparam int SAMP_W   = 16;
   localparam int PATH_W   = 18;
   localparam int CORDIC_W = 24;
   localparam int PHASE_W  = 32;
   localparam int ZW       = 24;  // phase bits into the rotator
   localparam int DAC_W    = 16;

   typedef logic signed [PATH_W-1:0] path_t;
   typedef logic signed [DAC_W-1:0]  dac_t;
   typedef logic [7:0]               rate_t;
   typedef logic [3:0]               mux_t;

   localparam int CIC_N        = 4;
   localparam int CIC_LOG2_MAX = 7;
   localparam int CIC_ACC_W    = PATH_W + CIC_N * CIC_LOG2_MAX;  // full growth at rate 128

   localparam int CORDIC_STAGES = 20;
   localparam int CORDIC_XW     = CORDIC_W + 2;  // guard bits for gain and quadrant growth
   localparam int CORDIC_GAIN   = 107923;        // ~1.64676 in Q16

   // atan(2^-k) scaled so that 2^ZW is a full turn
   localparam int CORDIC_ATAN [CORDIC_STAGES] = '{
      2097152, 1238021, 654136, 332050, 166669, 83416, 41718, 20860, 10430, 5215,
      2608, 1304, 652, 326, 163, 81, 41, 20, 10, 5
   };

   function automatic int log2_rate(rate_t rate);
      int sh;
      sh = 0;
      for (int b = 0; b <= CIC_LOG2_MAX; b++) begin
         if (rate[b]) sh = b;  // highest set bit wins
      end
      return sh;
   endfunction

endpackage

//--- rtl/setting_reg.sv
module setting_reg #(
   parameter logic [dsp_tx_pkg::ADDR_W-1:0] MY_ADDR = '0,
   parameter type payload_t = logic [dsp_tx_pkg::DATA_W-1:0],
   parameter payload_t RST_VAL = '0
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            strobe_i,
   input  logic [dsp_tx_pkg::ADDR_W-1:0]   addr_i,
   input  logic [dsp_tx_pkg::DATA_W-1:0]   data_i,
   output payload_t                        out_o
);

   logic hit;

   assign hit = strobe_i && (addr_i == MY_ADDR);

   always_ff @(posedge clk) begin
      if (rst) begin
         out_o <= RST_VAL;
      end else if (hit) begin
         out_o <= payload_t'(data_i[$bits(payload_t)-1:0]);  // low bits only
      end
   end

endmodule

//--- rtl/interp_strober.sv
module interp_strober (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  dsp_tx_pkg::rate_t rate_i,
   output logic              strobe_o
);

   import dsp_tx_pkg::*;

   rate_t cnt;
   logic  tc;

   assign tc = run_i && (cnt == '0);  // terminal count

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         cnt <= '0;  // first pulse right after run rises
      end else if (tc) begin
         cnt <= rate_i - 1'b1;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // extra register stage on the request for timing
   always_ff @(posedge clk) begin
      if (rst) begin
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= tc;
      end
   end

endmodule

//--- rtl/cic_interp.sv
module cic_interp (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  dsp_tx_pkg::rate_t rate_i,
   input  logic              strobe_i,
   input  dsp_tx_pkg::path_t data_i,
   output dsp_tx_pkg::path_t data_o
);

   import dsp_tx_pkg::*;

   logic signed [CIC_ACC_W-1:0] comb_x    [CIC_N+1];
   logic signed [CIC_ACC_W-1:0] comb_dly  [CIC_N];
   logic signed [CIC_ACC_W-1:0] integ     [CIC_N];
   logic signed [CIC_ACC_W-1:0] integ_nxt [CIC_N];
   logic signed [CIC_ACC_W-1:0] stuffed;
   logic signed [CIC_ACC_W-1:0] scaled;
   logic                        stb_q;  // sample valid the cycle after the request

   always_comb begin
      comb_x[0] = CIC_ACC_W'(data_i);  // sign extend into the wide path
      for (int k = 0; k < CIC_N; k++) begin
         comb_x[k+1] = comb_x[k] - comb_dly[k];
      end
      stuffed = stb_q ? comb_x[CIC_N] : '0;  // zero stuffing between samples
      integ_nxt[0] = integ[0] + stuffed;
      for (int k = 1; k < CIC_N; k++) begin
         integ_nxt[k] = integ[k] + integ_nxt[k-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         stb_q <= 1'b0;
         for (int k = 0; k < CIC_N; k++) begin
            comb_dly[k] <= '0;
            integ[k]    <= '0;
         end
      end else begin
         stb_q <= strobe_i;
         if (stb_q) begin
            for (int k = 0; k < CIC_N; k++) begin
               comb_dly[k] <= comb_x[k];
            end
         end
         for (int k = 0; k < CIC_N; k++) begin
            integ[k] <= integ_nxt[k];  // integrators run every clock
         end
      end
   end

   // gain is rate^(N-1), a power of two here
   assign scaled = integ[CIC_N-1] >>> ((CIC_N - 1) * log2_rate(rate_i));

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         data_o <= '0;
      end else begin
         data_o <= path_t'(scaled[PATH_W-1:0]);
      end
   end

endmodule

//--- rtl/nco_cordic.sv
module nco_cordic (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   input  logic [dsp_tx_pkg::PHASE_W-1:0]   phase_inc_i,
   input  dsp_tx_pkg::path_t                i_i,
   input  dsp_tx_pkg::path_t                q_i,
   output dsp_tx_pkg::path_t                i_o,
   output dsp_tx_pkg::path_t                q_o
);

   import dsp_tx_pkg::*;

   logic [PHASE_W-1:0]          phase;
   logic [ZW-1:0]               z_in;
   logic signed [CORDIC_XW-1:0] x_in;
   logic signed [CORDIC_XW-1:0] y_in;
   logic signed [CORDIC_XW-1:0] x_s [CORDIC_STAGES+1];
   logic signed [CORDIC_XW-1:0] y_s [CORDIC_STAGES+1];
   logic signed [ZW-1:0]        z_s [CORDIC_STAGES];

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc_i;
      end
   end

   assign z_in = phase[PHASE_W-1 -: ZW];
   assign x_in = CORDIC_XW'(i_i) <<< (CORDIC_W - PATH_W);  // align to the cordic msbs
   assign y_in = CORDIC_XW'(q_i) <<< (CORDIC_W - PATH_W);

   // quadrant pre-rotation, residual angle left in [0, 90) degrees
   always_ff @(posedge clk) begin
      if (rst) begin
         x_s[0] <= '0;
         y_s[0] <= '0;
         z_s[0] <= '0;
      end else begin
         case (z_in[ZW-1 -: 2])
            2'd0: begin
               x_s[0] <= x_in;
               y_s[0] <= y_in;
            end
            2'd1: begin
               x_s[0] <= -y_in;  // +90
               y_s[0] <= x_in;
            end
            2'd2: begin
               x_s[0] <= -x_in;  // +180
               y_s[0] <= -y_in;
            end
            default: begin
               x_s[0] <= y_in;  // +270
               y_s[0] <= -x_in;
            end
         endcase
         z_s[0] <= {2'b00, z_in[ZW-3:0]};
      end
   end

   for (genvar k = 0; k < CORDIC_STAGES; k++) begin : g_stage
      always_ff @(posedge clk) begin
         if (rst) begin
            x_s[k+1] <= '0;
            y_s[k+1] <= '0;
         end else if (z_s[k][ZW-1]) begin  // residual negative, turn back
            x_s[k+1] <= x_s[k] + (y_s[k] >>> k);
            y_s[k+1] <= y_s[k] - (x_s[k] >>> k);
         end else begin
            x_s[k+1] <= x_s[k] - (y_s[k] >>> k);
            y_s[k+1] <= y_s[k] + (x_s[k] >>> k);
         end
      end

      if (k + 1 < CORDIC_STAGES) begin : g_z
         always_ff @(posedge clk) begin
            if (rst) begin
               z_s[k+1] <= '0;
            end else if (z_s[k][ZW-1]) begin
               z_s[k+1] <= z_s[k] + ZW'(CORDIC_ATAN[k]);
            end else begin
               z_s[k+1] <= z_s[k] - ZW'(CORDIC_ATAN[k]);
            end
         end
      end
   end

   // gain left in, same scale as the input
   assign i_o = x_s[CORDIC_STAGES][CORDIC_W-1 -: PATH_W];
   assign q_o = y_s[CORDIC_STAGES][CORDIC_W-1 -: PATH_W];

endmodule

//--- rtl/dac_scale_mux.sv
module dac_scale_mux (
   input  logic               clk,
   input  logic               rst,
   input  dsp_tx_pkg::path_t  i_i,
   input  dsp_tx_pkg::path_t  q_i,
   input  logic signed [15:0] scale_i_i,
   input  logic signed [15:0] scale_q_i,
   input  dsp_tx_pkg::mux_t   mux_a_i,
   input  dsp_tx_pkg::mux_t   mux_b_i,
   output dsp_tx_pkg::dac_t   dac_a_o,
   output dsp_tx_pkg::dac_t   dac_b_o
);

   import dsp_tx_pkg::*;

   logic signed [PATH_W+15:0] prod_i;
   logic signed [PATH_W+15:0] prod_q;

   function automatic dac_t pick(mux_t sel, logic signed [PATH_W+15:0] pi,
                                 logic signed [PATH_W+15:0] pq);
      case (sel)
         4'd0:    return dac_t'(pi[28:13]);  // scale of 0x2000 is unity
         4'd1:    return dac_t'(pq[28:13]);
         default: return '0;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         prod_i <= '0;
         prod_q <= '0;
      end else begin
         prod_i <= i_i * scale_i_i;
         prod_q <= q_i * scale_q_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end else begin
         dac_a_o <= pick(mux_a_i, prod_i, prod_q);
         dac_b_o <= pick(mux_b_i, prod_i, prod_q);
      end
   end

endmodule

//--- rtl/dsp_core_tx.sv
module dsp_core_tx (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              set_stb_i,
   input  logic [dsp_tx_pkg::ADDR_W-1:0]     set_addr_i,
   input  logic [dsp_tx_pkg::DATA_W-1:0]     set_data_i,
   input  logic [2*dsp_tx_pkg::SAMP_W-1:0]   sample_i,  // {i, q}
   input  logic                              run_i,
   output logic                              strobe_o,
   output dsp_tx_pkg::dac_t                  dac_a_o,
   output dsp_tx_pkg::dac_t                  dac_b_o
);

   import dsp_tx_pkg::*;

   logic [PHASE_W-1:0] phase_inc;
   logic [31:0]        scale_pair;
   logic signed [15:0] scale_i;
   logic signed [15:0] scale_q;
   rate_t              interp_rate;
   logic [7:0]         dacmux;
   mux_t               dacmux_a;
   mux_t               dacmux_b;
   path_t              bb_i;
   path_t              bb_q;
   path_t              cic_i;
   path_t              cic_q;
   path_t              rot_i;
   path_t              rot_q;

   setting_reg #(.MY_ADDR(SR_PHASE_INC), .payload_t(logic [PHASE_W-1:0])) sr_phase (
      .clk(clk), .rst(rst), .strobe_i(set_stb_i), .addr_i(set_addr_i),
      .data_i(set_data_i), .out_o(phase_inc));

   setting_reg #(.MY_ADDR(SR_SCALE), .payload_t(logic [31:0])) sr_scale (
      .clk(clk), .rst(rst), .strobe_i(set_stb_i), .addr_i(set_addr_i),
      .data_i(set_data_i), .out_o(scale_pair));

   setting_reg #(.MY_ADDR(SR_RATE), .payload_t(rate_t), .RST_VAL(rate_t'(1))) sr_rate (
      .clk(clk), .rst(rst), .strobe_i(set_stb_i), .addr_i(set_addr_i),
      .data_i(set_data_i), .out_o(interp_rate));

   setting_reg #(.MY_ADDR(SR_DACMUX), .payload_t(logic [7:0])) sr_dacmux (
      .clk(clk), .rst(rst), .strobe_i(set_stb_i), .addr_i(set_addr_i),
      .data_i(set_data_i), .out_o(dacmux));

   assign scale_i  = scale_pair[31:16];
   assign scale_q  = scale_pair[15:0];
   assign dacmux_a = dacmux[3:0];
   assign dacmux_b = dacmux[7:4];

   assign bb_i = {sample_i[2*SAMP_W-1:SAMP_W], 2'b00};  // widen to the channel path
   assign bb_q = {sample_i[SAMP_W-1:0], 2'b00};

   interp_strober u_strober (
      .clk(clk), .rst(rst), .run_i(run_i), .rate_i(interp_rate), .strobe_o(strobe_o));

   cic_interp u_cic_i (
      .clk(clk), .rst(rst), .run_i(run_i), .rate_i(interp_rate),
      .strobe_i(strobe_o), .data_i(bb_i), .data_o(cic_i));

   cic_interp u_cic_q (
      .clk(clk), .rst(rst), .run_i(run_i), .rate_i(interp_rate),
      .strobe_i(strobe_o), .data_i(bb_q), .data_o(cic_q));

   nco_cordic u_nco (
      .clk(clk), .rst(rst), .run_i(run_i), .phase_inc_i(phase_inc),
      .i_i(cic_i), .q_i(cic_q), .i_o(rot_i), .q_o(rot_q));

   dac_scale_mux u_out (
      .clk(clk), .rst(rst), .i_i(rot_i), .q_i(rot_q),
      .scale_i_i(scale_i), .scale_q_i(scale_q),
      .mux_a_i(dacmux_a), .mux_b_i(dacmux_b),
      .dac_a_o(dac_a_o), .dac_b_o(dac_b_o));

endmodule

//--- tb/dsp_core_tx_chk.sv
module dsp_core_tx_chk (
   input logic               clk,
   input logic               rst,
   input logic               run_i,
   input logic               strobe_i,
   input dsp_tx_pkg::rate_t  rate_i,
   input dsp_tx_pkg::mux_t   mux_a_i,
   input dsp_tx_pkg::mux_t   mux_b_i,
   input dsp_tx_pkg::dac_t   dac_a_i,
   input dsp_tx_pkg::dac_t   dac_b_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;

   // strobe is registered, so it trails run by one cycle
   a_strobe_run: assert property (@(posedge clk) disable iff (rst)
      strobe_i |-> $past(run_i))
      else begin
         $error("strobe_o high although run_i was low on the cycle before");
         fail_cnt++;
      end

   a_strobe_single: assert property (@(posedge clk) disable iff (rst)
      (strobe_i && rate_i > 1) |=> !strobe_i)
      else begin
         $error("strobe_o high on two cycles in a row with rate above 1");
         fail_cnt++;
      end

   a_mux_a_zero: assert property (@(posedge clk) disable iff (rst)
      (mux_a_i > 1) |=> (dac_a_i == 0))  // output is one register behind the selector
      else begin
         $error("dac_a_o not zero for a selector above 1");
         fail_cnt++;
      end

   a_mux_b_zero: assert property (@(posedge clk) disable iff (rst)
      (mux_b_i > 1) |=> (dac_b_i == 0))
      else begin
         $error("dac_b_o not zero for a selector above 1");
         fail_cnt++;
      end

endmodule

bind dsp_core_tx dsp_core_tx_chk u_chk (
   .clk(clk), .rst(rst), .run_i(run_i), .strobe_i(strobe_o), .rate_i(interp_rate),
   .mux_a_i(dacmux_a), .mux_b_i(dacmux_b), .dac_a_i(dac_a_o), .dac_b_i(dac_b_o));

//--- tb/tb_dsp_core_tx.sv
module tb_dsp_core_tx;
   timeunit 1ns;
   timeprecision 1ps;

   import dsp_tx_pkg::*;

   localparam int TOL      = 4;     // lsb allowed on predicted dac values
   localparam int WAIT_MAX = 4000;  // cycle limit for every wait loop
   localparam int STEADY   = 64;    // longer than the sample to dac latency
   localparam int UNITY    = 16384; // scale of 0x4000

   logic                clk = 1'b0;
   logic                rst;
   logic                set_stb;
   logic [ADDR_W-1:0]   set_addr;
   logic [DATA_W-1:0]   set_data;
   logic [2*SAMP_W-1:0] sample;
   logic                run;
   logic                strobe;
   dac_t                dac_a;
   dac_t                dac_b;
   int                  n_checks = 0;
   int                  n_errors = 0;
   int                  samp_i;
   int                  samp_q;

   dsp_core_tx uut (
      .clk(clk), .rst(rst), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .sample_i(sample), .run_i(run), .strobe_o(strobe),
      .dac_a_o(dac_a), .dac_b_o(dac_b));

   always #5 clk = ~clk;

   task automatic write_setting(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(negedge clk);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge clk);
      set_stb  = 1'b0;
   endtask

   task automatic check_dac(input string name, input dac_t got, input dac_t exp, input int tol);
      n_checks++;
      if (int'(got) - int'(exp) > tol || int'(exp) - int'(got) > tol) begin
         n_errors++;
         $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp, input int tol);
      n_checks++;
      if (got - exp > tol || exp - got > tol) begin
         n_errors++;
         $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // widened sample times cordic gain in Q16 times scale, then down by 2^13
   function automatic dac_t expect_dac(input int samp, input int scale);
      longint acc;
      acc = longint'(samp) * 4 * CORDIC_GAIN * scale;
      return dac_t'((acc + (64'sd1 <<< 28)) >>> 29);
   endfunction

   function automatic int pick_sample();
      int mag;
      mag = 500 + int'($urandom % 1500);  // keeps the scaled output inside 16 bits
      return ($urandom % 2) ? -mag : mag;
   endfunction

   // dac pair has to repeat with the given period for STEADY cycles in a row,
   // so an old value still in the pipeline cannot count as settled
   task automatic wait_steady(input int period);
      logic [2*DAC_W-1:0] hist [$];
      int same;
      same = 0;
      for (int c = 0; c < WAIT_MAX && same < STEADY; c++) begin
         @(negedge clk);
         hist.push_back({dac_a, dac_b});
         if (hist.size() > period) begin
            same = (hist[0] == {dac_a, dac_b}) ? same + 1 : 0;
            hist.delete(0);
         end
      end
      if (same < STEADY) begin
         n_errors++;
         $display("DAC outputs did not settle within %0d cycles", WAIT_MAX);
      end
   endtask

   task automatic count_strobes(input int cycles, output int pulses);
      pulses = 0;
      repeat (cycles) begin
         @(negedge clk);
         pulses += int'(strobe);
      end
   endtask

   task automatic reset_idle();
      int pulses;
      pulses = 0;
      for (int c = 0; c < 50; c++) begin
         @(negedge clk);
         pulses += int'(strobe);
         check_dac("dac_a_o", dac_a, '0, 0);
         check_dac("dac_b_o", dac_b, '0, 0);
      end
      check_count("strobe_o pulses", pulses, 0, 0);
   endtask

   task automatic strobe_rate(input rate_t rate);
      int pulses;
      int c;
      write_setting(SR_RATE, DATA_W'(rate));
      run = 1'b1;
      c = 0;
      while (!strobe && c < WAIT_MAX) begin
         @(negedge clk);
         c++;
      end
      if (!strobe) begin
         n_errors++;
         $display("no strobe_o pulse after run_i rose, rate %0d", rate);
      end
      count_strobes(256 * int'(rate), pulses);
      check_count("strobe_o pulses", pulses, 256, 1);
      run = 1'b0;
      repeat (4) @(negedge clk);
   endtask

   task automatic dc_path();
      write_setting(SR_PHASE_INC, '0);
      write_setting(SR_SCALE, 32'h4000_4000);
      write_setting(SR_DACMUX, 32'h10);  // a from i, b from q
      write_setting(SR_RATE, 32'd8);
      sample = {samp_i[15:0], samp_q[15:0]};
      run = 1'b1;
      wait_steady(1);
      check_dac("dac_a_o", dac_a, expect_dac(samp_i, UNITY), TOL);
      check_dac("dac_b_o", dac_b, expect_dac(samp_q, UNITY), TOL);
   endtask

   task automatic freq_shift();
      dac_t first;
      dac_t pred;
      pred = expect_dac(samp_i, UNITY);
      sample = {samp_i[15:0], 16'h0000};
      write_setting(SR_PHASE_INC, 32'h8000_0000);  // half a turn per clock
      wait_steady(2);
      first = dac_a;
      @(negedge clk);
      if (first < 0) begin
         pred = -pred;
      end
      check_dac("dac_a_o", first, pred, TOL);
      check_dac("dac_a_o", dac_a, -pred, TOL);
   endtask

   task automatic mux_scale();
      write_setting(SR_PHASE_INC, '0);
      run = 1'b0;  // restart clears the phase left at half a turn
      repeat (4) @(negedge clk);
      sample = {samp_i[15:0], samp_q[15:0]};
      run = 1'b1;
      write_setting(SR_DACMUX, 32'h01);  // swapped
      wait_steady(1);
      check_dac("dac_a_o", dac_a, expect_dac(samp_q, UNITY), TOL);
      check_dac("dac_b_o", dac_b, expect_dac(samp_i, UNITY), TOL);
      write_setting(SR_DACMUX, 32'h05);
      wait_steady(1);
      check_dac("dac_a_o", dac_a, '0, 0);
      check_dac("dac_b_o", dac_b, expect_dac(samp_i, UNITY), TOL);
      write_setting(SR_DACMUX, 32'h10);
      write_setting(SR_SCALE, 32'hc000_c000);  // -0x4000 on both
      wait_steady(1);
      check_dac("dac_a_o", dac_a, expect_dac(samp_i, -UNITY), TOL);
      check_dac("dac_b_o", dac_b, expect_dac(samp_q, -UNITY), TOL);
   endtask

   task automatic run_drop();
      int pulses;
      int c;
      run = 1'b0;
      repeat (2) @(negedge clk);  // last request can still sit in the output register
      count_strobes(100, pulses);
      check_count("strobe_o pulses", pulses, 0, 0);
      c = 0;
      while ((dac_a != 0 || dac_b != 0) && c < WAIT_MAX) begin
         @(negedge clk);
         c++;
      end
      check_dac("dac_a_o", dac_a, '0, 0);
      check_dac("dac_b_o", dac_b, '0, 0);
   endtask

   initial begin
      void'($urandom(32'hed85_68a1));
      rst      = 1'b1;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      sample   = '0;
      run      = 1'b0;
      samp_i   = pick_sample();
      samp_q   = pick_sample();
      repeat (4) @(negedge clk);
      rst = 1'b0;
      reset_idle();
      strobe_rate(8'd1);
      strobe_rate(8'd4);
      strobe_rate(8'd32);
      dc_path();
      freq_shift();
      mux_scale();
      run_drop();
      n_errors += uut.u_chk.fail_cnt;
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               n_checks, n_errors, uut.u_chk.fail_cnt);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- all.f
rtl/dsp_tx_pkg.sv
rtl/setting_reg.sv
rtl/interp_strober.sv
rtl/cic_interp.sv
rtl/nco_cordic.sv
rtl/dac_scale_mux.sv
rtl/dsp_core_tx.sv
tb/dsp_core_tx_chk.sv
tb/tb_dsp_core_tx.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_dsp_core_tx -f all.f -o sim_tx > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tx +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "simulator returned a nonzero status"
grep -q "^TEST PASS$" sim.log && echo "pass message found in sim.log" \
   || { echo "pass message missing, see sim.log"; exit 1; }
